// File: src/irq_pkg.sv
// Package irq_pkg: line count, ID width, ID and line-vector types, FIFO status and event structs
package irq_pkg;

    // Number of interrupt lines; the ID width follows from it
    localparam int NUM_IRQ = 8;
    localparam int ID_W    = 3;

    // Interrupt ID, 0 to NUM_IRQ-1
    typedef logic [ID_W-1:0] irq_id_t;

    // One bit per interrupt line
    typedef logic [NUM_IRQ-1:0] irq_vec_t;

    // ID FIFO status, level covers depths up to 15
    typedef struct packed {
        logic       empty;
        logic       full;
        logic [3:0] level;
    } fifo_status_t;

    // Output side of the controller
    typedef struct packed {
        logic    active;     // Drives irq_out
        irq_id_t id;         // Presented ID
        logic    timed_out;  // One-cycle pulse on ack timeout
    } irq_event_t;

endpackage

// File: src/irq_pending.sv
// Module irq_pending: input synchronizer, rising-edge detect, pending bits, lowest-line select
`timescale 1ns/1ps

module irq_pending (
    input  logic                  clk,
    input  logic                  rst_n,
    input  irq_pkg::irq_vec_t     irq_in,
    input  irq_pkg::fifo_status_t fifo_status,
    output logic                  wr_en,
    output irq_pkg::irq_id_t      wr_id
);

    // Two synchronizer stages and the delayed level used for edge detection
    irq_pkg::irq_vec_t sync_q1;
    irq_pkg::irq_vec_t sync_q2;
    irq_pkg::irq_vec_t level_q;
    irq_pkg::irq_vec_t rise;
    irq_pkg::irq_vec_t pending;
    irq_pkg::irq_vec_t clr_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            level_q <= '0;
        end else begin
            sync_q1 <= irq_in;
            sync_q2 <= sync_q1;
            level_q <= sync_q2;
        end
    end

    assign rise = sync_q2 & ~level_q;

    // Lowest set pending bit wins
    always_comb begin
        wr_id = '0;
        for (int i = irq_pkg::NUM_IRQ - 1; i >= 0; i--) begin
            if (pending[i]) begin
                wr_id = irq_pkg::irq_id_t'(i);
            end
        end
    end

    // Full FIFO holds requests back in the pending bits
    assign wr_en = (|pending) && !fifo_status.full;

    always_comb begin
        clr_mask = '0;
        if (wr_en) begin
            clr_mask[wr_id] = 1'b1;
        end
    end

    // Repeated edges merge into one bit; a new edge on the
    // bit being enqueued keeps it set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | rise;
        end
    end

endmodule

// File: src/irq_id_fifo.sv
// Module irq_id_fifo: circular interrupt ID queue with head/tail pointers and status
`timescale 1ns/1ps

module irq_id_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  irq_pkg::irq_id_t      wr_id,
    input  logic                  rd_en,
    output irq_pkg::irq_id_t      rd_id,
    output irq_pkg::fifo_status_t status
);

    localparam int               PTR_W    = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [3:0]       FULL_LVL = 4'(DEPTH);

    irq_pkg::irq_id_t mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [3:0]       level;

    // Pointer advance with wrap at the last entry
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    // Storage; the writer side already honors full
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[tail] <= wr_id;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (wr_en) begin
                tail <= next_ptr(tail);
            end
            if (rd_en) begin
                head <= next_ptr(head);
            end
        end
    end

    // Simultaneous write and read leave the level as is
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   level <= level + 4'd1;
                2'b01:   level <= level - 4'd1;
                default: level <= level;
            endcase
        end
    end

    // Head entry shown without a read cycle
    assign rd_id = mem[head];

    assign status.empty = (level == 4'd0);
    assign status.full  = (level == FULL_LVL);
    assign status.level = level;

endmodule

// File: src/ack_timer.sv
// Module ack_timer: presentation cycle counter with expiry flag
`timescale 1ns/1ps

module ack_timer #(
    parameter int ACK_TIMEOUT = 12
) (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic expired
);

    localparam int               CNT_W = $clog2(ACK_TIMEOUT);
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(ACK_TIMEOUT - 1);

    logic [CNT_W-1:0] count;

    // Clears whenever the FSM is not presenting
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run) begin
            count <= '0;
        end else if (count != LIMIT) begin
            count <= count + 1'b1;
        end
    end

    // Last allowed cycle of the presentation
    assign expired = run && (count == LIMIT);

endmodule

// File: src/irq_dispatch_fsm.sv
// Module irq_dispatch_fsm: pops IDs, presents them, handles ack and timeout
`timescale 1ns/1ps

module irq_dispatch_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  irq_pkg::fifo_status_t fifo_status,
    input  irq_pkg::irq_id_t      head_id,
    input  logic                  irq_ack,
    input  logic                  expired,
    output logic                  rd_en,
    output logic                  timer_run,
    output irq_pkg::irq_event_t   irq_event
);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        PRESENT = 2'd1,
        RETIRE  = 2'd2
    } state_t;

    state_t state;

    // Pop only from IDLE
    assign rd_en     = (state == IDLE) && !fifo_status.empty;
    assign timer_run = (state == PRESENT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            irq_event <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_en) begin
                        // Output rises on the popping edge with the head ID
                        state               <= PRESENT;
                        irq_event.active    <= 1'b1;
                        irq_event.id        <= head_id;
                        irq_event.timed_out <= 1'b0;
                    end
                end
                PRESENT: begin
                    // Ack wins over a timeout in the same cycle
                    if (irq_ack) begin
                        state            <= RETIRE;
                        irq_event.active <= 1'b0;
                    end else if (expired) begin
                        state               <= RETIRE;
                        irq_event.active    <= 1'b0;
                        irq_event.timed_out <= 1'b1;
                    end
                end
                RETIRE: begin
                    // Gap cycle, ID stays visible during the timeout pulse
                    state               <= IDLE;
                    irq_event.timed_out <= 1'b0;
                end
                default: begin
                    state     <= IDLE;
                    irq_event <= '0;
                end
            endcase
        end
    end

endmodule

// File: src/irq_fifo_ctrl.sv
// Module irq_fifo_ctrl: queued interrupt controller top with capture, ID FIFO, ack timer and FSM
`timescale 1ns/1ps

module irq_fifo_ctrl #(
    parameter int DEPTH       = 4,
    parameter int ACK_TIMEOUT = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  irq_pkg::irq_vec_t     irq_in,
    input  logic                  irq_ack,
    output logic                  irq_out,
    output irq_pkg::irq_id_t      irq_id,
    output logic                  irq_timeout,
    output irq_pkg::fifo_status_t irq_status
);

    // Capture to queue
    logic                  wr_en;
    irq_pkg::irq_id_t      wr_id;

    // Queue to dispatch
    logic                  rd_en;
    irq_pkg::irq_id_t      head_id;
    irq_pkg::fifo_status_t fifo_status;

    // Dispatch to timer and outputs
    logic                  timer_run;
    logic                  expired;
    irq_pkg::irq_event_t   irq_event;

    irq_pending u_pending (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_in      (irq_in),
        .fifo_status (fifo_status),
        .wr_en       (wr_en),
        .wr_id       (wr_id)
    );

    irq_id_fifo #(
        .DEPTH (DEPTH)
    ) u_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr_en),
        .wr_id  (wr_id),
        .rd_en  (rd_en),
        .rd_id  (head_id),
        .status (fifo_status)
    );

    ack_timer #(
        .ACK_TIMEOUT (ACK_TIMEOUT)
    ) u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (timer_run),
        .expired (expired)
    );

    irq_dispatch_fsm u_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .fifo_status (fifo_status),
        .head_id     (head_id),
        .irq_ack     (irq_ack),
        .expired     (expired),
        .rd_en       (rd_en),
        .timer_run   (timer_run),
        .irq_event   (irq_event)
    );

    assign irq_out     = irq_event.active;
    assign irq_id      = irq_event.id;
    assign irq_timeout = irq_event.timed_out;
    assign irq_status  = fifo_status;

endmodule

// File: sim/irq_fifo_ctrl_asserts.sv
// Module irq_fifo_ctrl_asserts and its bind: output protocol and FIFO write checks
`timescale 1ns/1ps

module irq_fifo_ctrl_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  irq_out,
    input irq_pkg::irq_id_t      irq_id,
    input logic                  irq_timeout,
    input logic                  irq_ack,
    input logic                  wr_en,
    input irq_pkg::fifo_status_t fifo_status
);

    // Number of assertion failures so far
    int fail_count = 0;

    // ID holds for the whole presentation
    id_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (irq_out && $past(irq_out)) |-> (irq_id == $past(irq_id)))
        else begin
            $error("irq_id changed while irq_out stayed high");
            fail_count++;
        end

    timeout_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        irq_timeout |=> !irq_timeout)
        else begin
            $error("irq_timeout stayed high for more than one cycle");
            fail_count++;
        end

    // Capture side must hold back while the queue is full
    no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_status.full |-> !wr_en)
        else begin
            $error("ID FIFO written while full");
            fail_count++;
        end

    ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (irq_out && irq_ack) |=> !irq_out)
        else begin
            $error("irq_out still high the cycle after an ack");
            fail_count++;
        end

endmodule

bind irq_fifo_ctrl irq_fifo_ctrl_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .irq_out     (irq_out),
    .irq_id      (irq_id),
    .irq_timeout (irq_timeout),
    .irq_ack     (irq_ack),
    .wr_en       (wr_en),
    .fifo_status (fifo_status)
);

// File: sim/irq_fifo_ctrl_tb.sv
// Module irq_fifo_ctrl_tb: table-driven testbench with order model, compare tasks and cycle limit
`timescale 1ns/1ps

module irq_fifo_ctrl_tb;

    localparam int DEPTH       = 4;
    localparam int ACK_TIMEOUT = 12;
    localparam int NUM_ROWS    = 6;
    localparam int MAX_STEPS   = 24;
    localparam int NEVER       = 255;

    logic                  clk = 1'b0;
    logic                  rst_n;
    irq_pkg::irq_vec_t     irq_in;
    logic                  irq_ack;
    logic                  irq_out;
    irq_pkg::irq_id_t      irq_id;
    logic                  irq_timeout;
    irq_pkg::fifo_status_t irq_status;

    // Test table with one row per test
    string             row_name  [NUM_ROWS];
    int                row_steps [NUM_ROWS];
    irq_pkg::irq_vec_t row_pat   [NUM_ROWS][MAX_STEPS];
    int                row_ids   [NUM_ROWS];
    irq_pkg::irq_id_t  row_exp   [NUM_ROWS][8];
    int                row_delay [NUM_ROWS][8];
    bit                row_full  [NUM_ROWS];

    int errors      = 0;
    int cycles      = 0;
    int cycle_limit = 0;
    int seed        = 84;

    irq_fifo_ctrl #(
        .DEPTH       (DEPTH),
        .ACK_TIMEOUT (ACK_TIMEOUT)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_in      (irq_in),
        .irq_ack     (irq_ack),
        .irq_out     (irq_out),
        .irq_id      (irq_id),
        .irq_timeout (irq_timeout),
        .irq_status  (irq_status)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("simulation timed out after %0d cycles", cycles);
                $display("Errors found");
                $finish;
            end
        end
    end

    // Inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_id(input string name, input irq_pkg::irq_id_t exp,
                            input irq_pkg::irq_id_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected ID %0d, actual ID %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_event(input string name, input irq_pkg::irq_event_t exp,
                               input irq_pkg::irq_event_t act);
        if (exp !== act) begin
            $write("Mismatch in %s: expected out=%0b id=%0d timeout=%0b, ",
                   name, exp.active, exp.id, exp.timed_out);
            $display("actual out=%0b id=%0d timeout=%0b", act.active, act.id, act.timed_out);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input irq_pkg::fifo_status_t exp,
                                input irq_pkg::fifo_status_t act);
        if (exp !== act) begin
            $write("Mismatch in %s: expected empty=%0b full=%0b level=%0d, ",
                   name, exp.empty, exp.full, exp.level);
            $display("actual empty=%0b full=%0b level=%0d", act.empty, act.full, act.level);
            errors++;
        end
    endtask

    // Pattern and delays take one byte per entry and IDs one nibble each
    task automatic add_row(input int idx, input string name, input int n_steps,
                           input logic [63:0] pat, input int n_ids,
                           input logic [31:0] ids, input logic [63:0] dly, input bit chk_full);
        row_name[idx]  = name;
        row_steps[idx] = n_steps;
        row_ids[idx]   = n_ids;
        row_full[idx]  = chk_full;
        for (int i = 0; i < n_steps; i++) begin
            row_pat[idx][i] = pat[8*i +: 8];
        end
        for (int i = 0; i < n_ids; i++) begin
            row_exp[idx][i]   = ids[4*i +: 3];
            row_delay[idx][i] = int'(dly[8*i +: 8]);
        end
    endtask

    // Lines never repeat and each step is followed by a drain gap, so the
    // order is arrival order with the lowest line first within a step
    task automatic add_random_row(input int idx);
        irq_pkg::irq_vec_t vec;
        irq_pkg::irq_vec_t used;
        int                r;
        int                n;
        used = '0;
        n    = 0;
        row_name[idx]  = "random_mix";
        row_steps[idx] = 21;
        row_full[idx]  = 1'b0;
        for (int s = 0; s < 3; s++) begin
            vec = irq_pkg::irq_vec_t'($random(seed)) & ~used;
            for (int b = 0; b < irq_pkg::NUM_IRQ; b++) begin
                if (vec[b] && n < DEPTH + 1) begin
                    row_exp[idx][n] = irq_pkg::irq_id_t'(b);
                    used[b] = 1'b1;
                    n++;
                end else begin
                    vec[b] = 1'b0;
                end
            end
            row_pat[idx][7*s] = vec;
            for (int g = 1; g < 7; g++) begin
                row_pat[idx][7*s+g] = '0;
            end
        end
        if (n == 0) begin
            row_pat[idx][0] = 8'h01;
            row_exp[idx][0] = '0;
            n = 1;
        end
        row_ids[idx] = n;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            row_delay[idx][i] = (r[1:0] == 2'b00) ? NEVER : int'(r[6:4]) % 6;
        end
    endtask

    task automatic drive_pattern(input int idx);
        for (int s = 0; s < row_steps[idx]; s++) begin
            irq_in = row_pat[idx][s];
            next_cycle();
        end
        irq_in = '0;
    endtask

    // Waits for each presentation, checks it and acks it or lets it time out
    task automatic serve_row(input int idx);
        irq_pkg::irq_event_t   exp_ev;
        irq_pkg::irq_event_t   act_ev;
        irq_pkg::fifo_status_t full_st;
        int                    wait_n;
        full_st = '{empty: 1'b0, full: 1'b1, level: 4'(DEPTH)};
        for (int k = 0; k < row_ids[idx]; k++) begin
            while (!irq_out) begin
                next_cycle();
            end
            check_id(row_name[idx], row_exp[idx][k], irq_id);
            if (row_full[idx] && k == 0) begin
                wait_n = 0;
                while (!irq_status.full && wait_n < 10) begin
                    next_cycle();
                    wait_n++;
                end
                if (!irq_status.full) begin
                    $display("FIFO never reported full in %s", row_name[idx]);
                    errors++;
                end else begin
                    check_status(row_name[idx], full_st, irq_status);
                end
            end
            exp_ev = '{active: 1'b0, id: row_exp[idx][k], timed_out: 1'b0};
            if (row_delay[idx][k] == NEVER) begin
                exp_ev.timed_out = 1'b1;
                // Presentation ends after ACK_TIMEOUT cycles without an ack
                repeat (ACK_TIMEOUT) next_cycle();
            end else begin
                repeat (row_delay[idx][k]) next_cycle();
                irq_ack = 1'b1;
                next_cycle();
                irq_ack = 1'b0;
            end
            act_ev = '{active: irq_out, id: irq_id, timed_out: irq_timeout};
            check_event(row_name[idx], exp_ev, act_ev);
        end
    endtask

    task automatic check_idle(input int idx);
        irq_pkg::fifo_status_t empty_st;
        empty_st = '{empty: 1'b1, full: 1'b0, level: 4'd0};
        repeat (12) begin
            next_cycle();
            if (irq_out) begin
                $display("Unexpected extra presentation of ID %0d after %s",
                         irq_id, row_name[idx]);
                errors++;
            end
        end
        check_status(row_name[idx], empty_st, irq_status);
    endtask

    initial begin
        rst_n   = 1'b0;
        irq_in  = '0;
        irq_ack = 1'b0;
        add_row(0, "single_edge", 1, 64'h08, 1, 32'h3, 64'h02, 1'b0);
        add_row(1, "simultaneous", 1, 64'h64, 3, 32'h652, 64'h010101, 1'b0);
        add_row(2, "merge_repeat", 5, 64'h80_00_80_00_8F, 5, 32'h73210, 64'h0101010101, 1'b0);
        add_row(3, "back_pressure", 6, 64'h10_01_40_02_08_20, 6, 32'h406135, 64'h0, 1'b1);
        add_row(4, "ack_timeout", 1, 64'h82, 2, 32'h71, 64'h02FF, 1'b0);
        add_random_row(5);
        for (int i = 0; i < NUM_ROWS; i++) begin
            cycle_limit += row_ids[i] * (ACK_TIMEOUT + 4) + 20;
        end

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        check_event("reset", '0, '{active: irq_out, id: irq_id, timed_out: irq_timeout});
        check_status("reset", '{empty: 1'b1, full: 1'b0, level: 4'd0}, irq_status);

        for (int i = 0; i < NUM_ROWS; i++) begin
            fork
                drive_pattern(i);
                serve_row(i);
            join
            check_idle(i);
        end

        // Assertion failures count as errors
        errors += dut0.u_asserts.fail_count;
        $display("Finished %0d tests after %0d cycles with %0d errors", NUM_ROWS, cycles, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: project.f
src/irq_pkg.sv
src/irq_pending.sv
src/irq_id_fifo.sv
src/ack_timer.sv
src/irq_dispatch_fsm.sv
src/irq_fifo_ctrl.sv
sim/irq_fifo_ctrl_asserts.sv
sim/irq_fifo_ctrl_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the queued interrupt controller

TOP = irq_fifo_ctrl_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
